/* src.f */
source/main_bus_pkg.sv
source/bus_decode.sv
source/bus_access.sv
source/sys_ctrl.sv
source/read_select.sv
source/main_bus_top.sv
verification/tb_clock.sv
verification/main_bus_asserts.sv
verification/main_bus_tb.sv

/* verification/main_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module main_bus_tb;
    import main_bus_pkg::*;

    localparam int RAM_WAIT_MAX = 64;
    localparam int N_ACCESSES   = 25;

    logic        clk;
    logic        rst;
    logic        req = 1'b0;
    bus_req_t    cpu = '0;
    logic        ack;
    logic [15:0] rd_data;
    logic        rom_cs;
    logic        ram_cs;
    logic        ram_we;
    logic [21:1] main_addr;
    logic [15:0] rom_data  = '0;
    logic [15:0] ram_data  = '0;
    logic        rom_ok    = 1'b0;
    logic        ram_ok    = 1'b0;
    mem_we_t     we;
    logic [10:0] cpal_addr;
    logic [11:0] omem_addr;
    logic [11:0] vmem_addr;
    logic [15:0] cpal_dout = '0;
    logic [15:0] omem_dout = '0;
    logic [15:0] vmem_dout = '0;
    logic [ 7:0] vtimer    = '0;
    logic [ 6:0] joystick1 = '0;
    logic [ 6:0] joystick2 = '0;
    logic [ 6:0] joystick3 = '0;
    logic [ 6:0] joystick4 = '0;
    logic [ 3:0] cab_1p    = '0;
    logic [ 3:0] coin      = '0;
    logic [ 3:0] service   = '0;
    logic [ 3:0] dipsw     = '0;
    logic        dip_test  = 1'b0;
    logic        lvbl      = 1'b1;
    video_cfg_t  cfg;
    logic [ 2:0] ipl_n;

    integer      seed = 32'h360d_6c00;
    int          ok_delay = 0;
    int          rom_wait = 0;
    int          ram_wait = 0;
    int          errors = 0;
    int          checks = 0;
    mem_we_t     we_seen;
    logic        rom_cs_seen;

    logic [15:0] ram_mem  [0:1023];
    logic [15:0] cpal_mem [0:2047];
    logic [15:0] omem_mem [0:4095];
    logic [15:0] vmem_mem [0:4095];

    tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(4)) tb_clock_inst (.clk(clk), .rst(rst));

    main_bus_top #(.RAM_WAIT_MAX(RAM_WAIT_MAX)) main_bus_top_inst (
        .clk(clk), .rst(rst), .req(req), .cpu(cpu), .ack(ack), .rd_data(rd_data),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .ram_we(ram_we), .main_addr(main_addr),
        .rom_data(rom_data), .ram_data(ram_data), .rom_ok(rom_ok), .ram_ok(ram_ok),
        .we(we), .cpal_addr(cpal_addr), .omem_addr(omem_addr), .vmem_addr(vmem_addr),
        .cpal_dout(cpal_dout), .omem_dout(omem_dout), .vmem_dout(vmem_dout),
        .vtimer(vtimer), .joystick1(joystick1), .joystick2(joystick2),
        .joystick3(joystick3), .joystick4(joystick4), .cab_1p(cab_1p), .coin(coin),
        .service(service), .dipsw(dipsw), .dip_test(dip_test), .lvbl(lvbl),
        .cfg(cfg), .ipl_n(ipl_n)
    );

    bind bus_access main_bus_asserts main_bus_asserts_inst (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .ack    (ack),
        .rom_cs (rom_cs),
        .ram_cs (ram_cs),
        .commit (commit),
        .wr     (cpu.wr),
        .we     (we)
    );

    function automatic logic [15:0] fill_word(input int i);
        return 16'(i * 257) ^ 16'h3c5a;
    endfunction

    function automatic logic [15:0] rom_word(input logic [21:1] a);
        return a[16:1] ^ {a[21:18], 12'h000} ^ 16'h5a3c;
    endfunction

    // megabytes 1 and 2 sit swapped in the rom image
    function automatic logic [15:0] rom_expect(input logic [23:0] addr);
        logic [21:1] a;
        a = addr[21:1];
        if (addr[23:20] == 4'h1 || addr[23:20] == 4'h2) begin
            a[21:20] = {a[20], a[21]};
        end
        return rom_word(a);
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                                input logic [15:0] data,
                                                input logic [1:0]  dsn);
        logic [15:0] w;
        w = old;
        if (!dsn[1]) w[15:8] = data[15:8];
        if (!dsn[0]) w[7:0] = data[7:0];
        return w;
    endfunction

    // rom and ram answer after a random number of cycles with cs high
    always @(posedge clk) begin
        if (rst || !rom_cs) begin
            rom_wait <= 0;
            rom_ok   <= 1'b0;
        end else if (rom_wait >= ok_delay) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_word(main_addr);
        end else begin
            rom_wait <= rom_wait + 1;
        end
    end

    always @(posedge clk) begin
        if (rst || !ram_cs) begin
            ram_wait <= 0;
            ram_ok   <= 1'b0;
        end else if (ram_wait >= ok_delay) begin
            ram_ok <= 1'b1;
            if (ram_we && !cpu.dsn[1]) ram_mem[main_addr[10:1]][15:8] <= cpu.wdata[15:8];
            if (ram_we && !cpu.dsn[0]) ram_mem[main_addr[10:1]][7:0] <= cpu.wdata[7:0];
            ram_data <= ram_mem[main_addr[10:1]];
        end else begin
            ram_wait <= ram_wait + 1;
        end
    end

    always @(posedge clk) begin
        if (we.cpal_we[1]) cpal_mem[cpal_addr][15:8] <= cpu.wdata[15:8];
        if (we.cpal_we[0]) cpal_mem[cpal_addr][7:0] <= cpu.wdata[7:0];
        if (we.omem_we[1]) omem_mem[omem_addr][15:8] <= cpu.wdata[15:8];
        if (we.omem_we[0]) omem_mem[omem_addr][7:0] <= cpu.wdata[7:0];
        if (we.vmem_we[1]) vmem_mem[vmem_addr][15:8] <= cpu.wdata[7:0];  // fix ram takes low byte
        if (we.vmem_we[0]) vmem_mem[vmem_addr][7:0] <= cpu.wdata[7:0];
        cpal_dout <= cpal_mem[cpal_addr];
        omem_dout <= omem_mem[omem_addr];
        vmem_dout <= vmem_mem[vmem_addr];
    end

    task automatic bus_cycle(input logic [23:0] addr, input logic wr, input logic [1:0] dsn,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        @(negedge clk);
        cpu.addr    = addr[23:1];
        cpu.wr      = wr;
        cpu.dsn     = dsn;
        cpu.wdata   = wdata;
        ok_delay    = $random(seed) & 7;
        we_seen     = '0;
        rom_cs_seen = 1'b0;
        req         = 1'b1;
        do begin
            @(negedge clk);
            we_seen     = we_seen | we;
            rom_cs_seen = rom_cs_seen | rom_cs;
        end while (!ack);
        rdata = rd_data;
        req   = 1'b0;
        do @(negedge clk); while (ack);
    endtask

    task automatic write_word(input logic [23:0] addr, input logic [1:0] dsn,
                              input logic [15:0] data);
        logic [15:0] unused;
        bus_cycle(addr, 1'b1, dsn, data, unused);
    endtask

    task automatic read_word(input logic [23:0] addr, output logic [15:0] data);
        bus_cycle(addr, 1'b0, 2'b00, 16'h0000, data);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    initial begin : stimulus
        logic [15:0] rd;
        logic [15:0] exp;
        video_cfg_t  exp_cfg;
        int          afails;
        joystick1 = 7'($random(seed));
        joystick2 = 7'($random(seed));
        joystick3 = 7'($random(seed));
        joystick4 = 7'($random(seed));
        cab_1p    = 4'($random(seed));
        coin      = 4'($random(seed));
        service   = 4'($random(seed));
        dipsw     = 4'($random(seed));
        dip_test  = 1'($random(seed));
        vtimer    = 8'h9c;
        for (int i = 0; i < 4096; i++) begin
            if (i < 1024) ram_mem[i] = fill_word(i);
            if (i < 2048) cpal_mem[i] = fill_word(i);
            omem_mem[i] = fill_word(i);
            vmem_mem[i] = fill_word(i);
        end
        wait (rst === 1'b0);
        check_value("ipl_n", ipl_n, 16'h0007);

        // program rom, boot space and both swapped megabytes
        read_word(24'h000100, rd);
        check_value("rd_data", rd, rom_expect(24'h000100));
        read_word(24'h100200, rd);
        check_value("rd_data", rd, rom_expect(24'h100200));
        read_word(24'h2abcd0, rd);
        check_value("rd_data", rd, rom_expect(24'h2abcd0));
        write_word(24'h000200, 2'b00, 16'hdead);
        check_value("rom_cs", rom_cs_seen, 16'h0000);

        // work ram, byte merges on top of the fill
        exp = merge_bytes(fill_word(10'h020), 16'h1234, 2'b10);
        write_word(24'h380040, 2'b10, 16'h1234);
        read_word(24'h380040, rd);
        check_value("rd_data", rd, exp);
        exp = merge_bytes(exp, 16'hab00, 2'b01);
        write_word(24'h380040, 2'b01, 16'hab00);
        read_word(24'h380040, rd);
        check_value("rd_data", rd, exp);

        // palette upper lane only, object ram both lanes
        write_word(24'h300020, 2'b01, 16'hbeef);
        check_value("we", 16'(we_seen), 16'(mem_we_t'({2'b10, 2'b00, 2'b00})));
        read_word(24'h300020, rd);
        check_value("rd_data", rd, merge_bytes(fill_word(11'h010), 16'hbeef, 2'b01));
        write_word(24'h600100, 2'b00, 16'h55aa);
        check_value("we", 16'(we_seen), 16'(mem_we_t'({2'b00, 2'b11, 2'b00})));
        read_word(24'h600100, rd);
        check_value("rd_data", rd, 16'h55aa);

        // fix layer, one byte per lane
        write_word(24'h740010, 2'b10, 16'h125a);
        check_value("we", 16'(we_seen), 16'(mem_we_t'({2'b00, 2'b00, 2'b10})));
        write_word(24'h740012, 2'b10, 16'h77c3);
        check_value("we", 16'(we_seen), 16'(mem_we_t'({2'b00, 2'b00, 2'b01})));
        read_word(24'h740010, rd);
        check_value("rd_data", rd, 16'h005a);
        read_word(24'h740012, rd);
        check_value("rd_data", rd, 16'h00c3);

        read_word(24'h4c0000, rd);
        check_value("rd_data", rd, {8'h00, vtimer});

        // cabinet words on both values of address bit 1
        read_word(24'h480000, rd);
        check_value("rd_data", rd, {cab_1p[1], joystick2, cab_1p[0], joystick1});
        read_word(24'h480002, rd);
        check_value("rd_data", rd, {cab_1p[3], joystick4, cab_1p[2], joystick3});
        read_word(24'h480004, rd);
        check_value("rd_data", rd, {8'h00, service, coin});
        read_word(24'h480006, rd);
        check_value("rd_data", rd, {8'h00, dipsw, dip_test, 3'b111});
        read_word(24'hc00000, rd);
        check_value("rd_data", rd, 16'h0000);

        // system latches and the vblank interrupt
        write_word(24'h480008, 2'b00, 16'h44e0);
        exp_cfg = '{pri: 1'b1, gvflip: 1'b1, ghflip: 1'b1, l_r: 1'b1, l5mas: 1'b1,
                    psac_bank: 4'h0};
        check_value("cfg", 16'(cfg), 16'(exp_cfg));
        write_word(24'h48000c, 2'b10, 16'hff50);
        exp_cfg.psac_bank = 4'h5;
        check_value("cfg", 16'(cfg), 16'(exp_cfg));
        check_value("ipl_n", ipl_n, 16'h0007);
        @(negedge clk);
        lvbl = 1'b0;
        repeat (2) @(negedge clk);
        check_value("ipl_n", ipl_n, 16'h0002);   // level 5, active low
        lvbl = 1'b1;
        write_word(24'h480008, 2'b00, 16'h0000);
        @(negedge clk);
        exp_cfg = '{pri: 1'b0, gvflip: 1'b0, ghflip: 1'b0, l_r: 1'b0, l5mas: 1'b0,
                    psac_bank: 4'h5};
        check_value("cfg", 16'(cfg), 16'(exp_cfg));
        check_value("ipl_n", ipl_n, 16'h0007);

        repeat (2) @(negedge clk);
        afails = main_bus_top_inst.bus_access_inst.main_bus_asserts_inst.fails;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // worst case every access runs into the ram wait limit
    initial begin : watchdog
        repeat (N_ACCESSES * (RAM_WAIT_MAX + 10) + 20) @(posedge clk);
        $display("timeout, the bus accesses did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/main_bus_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module main_bus_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  req,
    input logic                  ack,
    input logic                  rom_cs,
    input logic                  ram_cs,
    input logic                  commit,
    input logic                  wr,
    input main_bus_pkg::mem_we_t we
);

    int fails = 0;  // read by the testbench at the end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
    else begin
        fails++;
        $error("ack rose while req was low");
    end

    // held while the master holds req
    ack_holds: assert property (@(posedge clk) disable iff (rst)
        ack && req |=> ack)
    else begin
        fails++;
        $error("ack dropped before req fell");
    end

    ack_release: assert property (@(posedge clk) disable iff (rst)
        ack && !req |=> !ack)
    else begin
        fails++;
        $error("ack did not fall one cycle after req fell");
    end

    cs_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(rom_cs && ram_cs))
    else begin
        fails++;
        $error("rom_cs and ram_cs high together");
    end

    strobe_single: assert property (@(posedge clk) disable iff (rst)
        (|we) || commit |=> !(|we) && !commit)
    else begin
        fails++;
        $error("write strobe longer than one cycle");
    end

    write_commits: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) && wr |-> $past(commit))
    else begin
        fails++;
        $error("write acknowledged without a commit pulse");
    end

    ack_after_reset: assert property (@(posedge clk) rst |=> !ack)
    else begin
        fails++;
        $error("ack high in the cycle after reset");
    end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* source/main_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module main_bus_top #(
    parameter int RAM_WAIT_MAX = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    // bus master side
    input  logic                    req,
    input  main_bus_pkg::bus_req_t  cpu,
    output logic                    ack,
    output logic [15:0]             rd_data,
    // external rom and ram
    output logic                    rom_cs,
    output logic                    ram_cs,
    output logic                    ram_we,
    output logic [21:1]             main_addr,
    input  logic [15:0]             rom_data,
    input  logic [15:0]             ram_data,
    input  logic                    rom_ok,
    input  logic                    ram_ok,
    // local memories
    output main_bus_pkg::mem_we_t   we,
    output logic [10:0]             cpal_addr,
    output logic [11:0]             omem_addr,
    output logic [11:0]             vmem_addr,
    input  logic [15:0]             cpal_dout,
    input  logic [15:0]             omem_dout,
    input  logic [15:0]             vmem_dout,
    input  logic [ 7:0]             vtimer,
    // cabinet
    input  logic [ 6:0]             joystick1,
    input  logic [ 6:0]             joystick2,
    input  logic [ 6:0]             joystick3,
    input  logic [ 6:0]             joystick4,
    input  logic [ 3:0]             cab_1p,
    input  logic [ 3:0]             coin,
    input  logic [ 3:0]             service,
    input  logic [ 3:0]             dipsw,
    input  logic                    dip_test,
    input  logic                    lvbl,
    // video and interrupt
    output main_bus_pkg::video_cfg_t cfg,
    output logic [ 2:0]             ipl_n
);
    import main_bus_pkg::*;

    bus_sel_t sel;
    logic     commit;
    logic     capture;

    // l_r picks the bank half of palette and fix ram
    assign cpal_addr = {cfg.l_r, cpu.addr[10:1]};
    assign vmem_addr = {cfg.l_r, cpu.addr[12:2]};   // byte wide, lane from bit 1
    assign omem_addr = cpu.addr[12:1];

    bus_decode bus_decode_inst (
        .cpu (cpu),
        .sel (sel)
    );

    bus_access #(
        .RAM_WAIT_MAX (RAM_WAIT_MAX)
    ) bus_access_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .cpu       (cpu),
        .sel       (sel),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .ack       (ack),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .ram_we    (ram_we),
        .commit    (commit),
        .capture   (capture),
        .main_addr (main_addr),
        .we        (we)
    );

    sys_ctrl sys_ctrl_inst (
        .clk    (clk),
        .rst    (rst),
        .commit (commit),
        .cpu    (cpu),
        .sel    (sel),
        .lvbl   (lvbl),
        .cfg    (cfg),
        .ipl_n  (ipl_n)
    );

    read_select read_select_inst (
        .clk         (clk),
        .capture     (capture),
        .sel         (sel),
        .addr1       (cpu.addr[1]),
        .rom_data    (rom_data),
        .ram_data    (ram_data),
        .rom_ok      (rom_ok),
        .ram_ok      (ram_ok),
        .cpal_dout   (cpal_dout),
        .omem_dout   (omem_dout),
        .vmem_dout   (vmem_dout),
        .vtimer_dout (vtimer),
        .joystick1   (joystick1),
        .joystick2   (joystick2),
        .joystick3   (joystick3),
        .joystick4   (joystick4),
        .cab_1p      (cab_1p),
        .coin        (coin),
        .service     (service),
        .dipsw       (dipsw),
        .dip_test    (dip_test),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

/* source/read_select.sv */
`timescale 1ns/1ps
`default_nettype none

module read_select (
    input  logic                   clk,
    input  logic                   capture,
    input  main_bus_pkg::bus_sel_t sel,
    input  logic                   addr1,
    input  logic [15:0]            rom_data,
    input  logic [15:0]            ram_data,
    input  logic                   rom_ok,
    input  logic                   ram_ok,
    input  logic [15:0]            cpal_dout,
    input  logic [15:0]            omem_dout,
    input  logic [15:0]            vmem_dout,
    input  logic [ 7:0]            vtimer_dout,
    input  logic [ 6:0]            joystick1,
    input  logic [ 6:0]            joystick2,
    input  logic [ 6:0]            joystick3,
    input  logic [ 6:0]            joystick4,
    input  logic [ 3:0]            cab_1p,
    input  logic [ 3:0]            coin,
    input  logic [ 3:0]            service,
    input  logic [ 3:0]            dipsw,
    input  logic                   dip_test,
    output logic [15:0]            rd_data
);
    import main_bus_pkg::*;

    logic [ 7:0] vmem_byte;
    logic [15:0] cab1_word;
    logic [15:0] cab2_word;

    assign vmem_byte = addr1 ? vmem_dout[7:0] : vmem_dout[15:8];

    // players 3/4 on the odd word, 1/2 on the even one
    assign cab1_word = addr1 ? {cab_1p[3], joystick4, cab_1p[2], joystick3}
                             : {cab_1p[1], joystick2, cab_1p[0], joystick1};
    assign cab2_word = addr1 ? {8'h00, dipsw, dip_test, 3'b111}
                             : {8'h00, service, coin};

    always_ff @(posedge clk) begin
        if (capture) begin
            case (sel.region)
                rom:     rd_data <= rom_ok ? rom_data : 16'h0000;  // zero on timeout
                ram:     rd_data <= ram_ok ? ram_data : 16'h0000;
                cpal:    rd_data <= cpal_dout;
                omem:    rd_data <= omem_dout;
                vmem:    rd_data <= {8'h00, vmem_byte};
                vtimer:  rd_data <= {8'h00, vtimer_dout};
                io_cab1: rd_data <= cab1_word;
                io_cab2: rd_data <= cab2_word;
                default: rd_data <= 16'h0000;   // latches read back as zero
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/sys_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     commit,
    input  main_bus_pkg::bus_req_t   cpu,
    input  main_bus_pkg::bus_sel_t   sel,
    input  logic                     lvbl,
    output main_bus_pkg::video_cfg_t cfg,
    output logic [2:0]               ipl_n
);
    import main_bus_pkg::*;

    logic [15:0] sys1;
    logic [15:0] sys2;
    logic        sys1_wr;
    logic        sys2_wr;
    logic        lvbl_l;
    logic        int5;

    assign sys1_wr = commit && sel.region == io_sys1;
    assign sys2_wr = commit && sel.region == io_sys2;

    // byte writes into both latches
    always_ff @(posedge clk) begin
        if (rst) begin
            sys1 <= '0;
            sys2 <= '0;
        end else begin
            if (sys1_wr && !cpu.dsn[1]) sys1[15:8] <= cpu.wdata[15:8];
            if (sys1_wr && !cpu.dsn[0]) sys1[ 7:0] <= cpu.wdata[ 7:0];
            if (sys2_wr && !cpu.dsn[1]) sys2[15:8] <= cpu.wdata[15:8];
            if (sys2_wr && !cpu.dsn[0]) sys2[ 7:0] <= cpu.wdata[ 7:0];
        end
    end

    assign cfg.pri       = sys1[14];
    assign cfg.l5mas     = sys1[10];
    assign cfg.l_r       = sys1[7];
    assign cfg.gvflip    = sys1[6];
    assign cfg.ghflip    = sys1[5];
    assign cfg.psac_bank = sys2[7:4];

    // vblank interrupt, held until the mask bit drops
    always_ff @(posedge clk) begin
        if (rst) begin
            lvbl_l <= 1'b1;
            int5   <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (!cfg.l5mas) begin
                int5 <= 1'b0;
            end else if (lvbl_l && !lvbl) begin   // start of blank
                int5 <= 1'b1;
            end
        end
    end

    assign ipl_n = int5 ? ~3'd5 : 3'b111;

endmodule

`default_nettype wire

/* source/bus_access.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_access #(
    parameter int RAM_WAIT_MAX = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  main_bus_pkg::bus_req_t cpu,
    input  main_bus_pkg::bus_sel_t sel,
    input  logic                   rom_ok,
    input  logic                   ram_ok,
    output logic                   ack,
    output logic                   rom_cs,
    output logic                   ram_cs,
    output logic                   ram_we,
    output logic                   commit,
    output logic                   capture,
    output logic [21:1]            main_addr,
    output main_bus_pkg::mem_we_t  we
);
    import main_bus_pkg::*;

    localparam int CW = $clog2(RAM_WAIT_MAX + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_done,
        st_release
    } state_t;

    state_t          state;
    logic [CW-1:0]   cnt;
    logic            ext_ok;
    logic            timeout;
    mem_we_t         wr_lanes;

    assign main_addr = sel.ext_addr;
    assign ext_ok    = (rom_cs && rom_ok) || (ram_cs && ram_ok);
    assign timeout   = cnt == CW'(RAM_WAIT_MAX - 1);   // stuck sdram, give up

    // byte lanes for the local memories
    always_comb begin
        wr_lanes.cpal_we = {2{cpu.wr && sel.region == cpal}} & ~cpu.dsn;
        wr_lanes.omem_we = {2{cpu.wr && sel.region == omem}} & ~cpu.dsn;
        // fix layer is byte wide on the low strobe, bit 1 picks the lane
        wr_lanes.vmem_we = {2{cpu.wr && sel.region == vmem && !cpu.dsn[0]}}
                         & {~cpu.addr[1], cpu.addr[1]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            cnt     <= '0;
            ack     <= 1'b0;
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            ram_we  <= 1'b0;
            commit  <= 1'b0;
            capture <= 1'b0;
            we      <= '0;
        end else begin
            commit  <= 1'b0;    // single cycle pulses
            capture <= 1'b0;
            we      <= '0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (req) begin
                        rom_cs <= sel.region == rom;
                        ram_cs <= sel.region == ram;
                        ram_we <= sel.region == ram && cpu.wr;
                        state  <= st_wait;
                    end
                end
                st_wait: begin
                    if (!sel.ext || ext_ok || timeout) begin
                        state <= st_done;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_done: begin
                    capture <= 1'b1;
                    commit  <= cpu.wr;
                    we      <= wr_lanes;
                    state   <= st_release;
                end
                default: begin
                    // chip selects held through the capture cycle
                    rom_cs <= 1'b0;
                    ram_cs <= 1'b0;
                    ram_we <= 1'b0;
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
    input  main_bus_pkg::bus_req_t cpu,
    output main_bus_pkg::bus_sel_t sel
);
    import main_bus_pkg::*;

    logic       boot_hit;
    logic       xrom_hit;
    logic       ram_hit;
    logic       cpal_hit;
    logic       gfx_hit;
    logic       misc_hit;
    logic [2:0] sub;
    logic [1:0] io_sub;

    assign sub    = cpu.addr[20:18];
    assign io_sub = cpu.addr[3:2];

    // pal equations
    assign boot_hit = cpu.addr[23:20] == BOOT_HI && !cpu.wr;    // boot rom is read only
    assign xrom_hit = cpu.addr[23:20] == XROM_HI_A || cpu.addr[23:20] == XROM_HI_B;
    assign ram_hit  = cpu.addr[23:19] == RAM_HI;
    assign cpal_hit = cpu.addr[23:19] == CPAL_HI;
    assign gfx_hit  = cpu.addr[23:21] == GFX_HI;
    assign misc_hit = cpu.addr[23:21] == MISC_HI;

    always_comb begin
        sel.region = none;
        if (boot_hit || xrom_hit) begin
            sel.region = rom;
        end else if (ram_hit) begin
            sel.region = ram;
        end else if (cpal_hit) begin
            sel.region = cpal;
        end else if (gfx_hit) begin
            // first 3-to-8 decoder
            if (sub == GFX_OMEM) begin
                sel.region = omem;
            end else if (sub == GFX_VMEM) begin
                sel.region = vmem;
            end
        end else if (misc_hit) begin
            // second 3-to-8 decoder
            if (sub == MISC_VTIMER) begin
                sel.region = vtimer;
            end else if (sub == MISC_IO) begin
                case (io_sub)
                    IO_CAB1: sel.region = io_cab1;
                    IO_CAB2: sel.region = io_cab2;
                    IO_SYS1: sel.region = io_sys1;
                    default: sel.region = io_sys2;
                endcase
            end
        end
    end

    always_comb begin
        sel.ext_addr = cpu.addr[21:1];
        // megabytes 1 and 2 trade places in the rom
        if (xrom_hit) begin
            sel.ext_addr[21:20] = {cpu.addr[20], cpu.addr[21]};
        end
        sel.ext = sel.region == rom || sel.region == ram;
    end

endmodule

`default_nettype wire

/* source/main_bus_pkg.sv */
`default_nettype none

package main_bus_pkg;

    // target of one cpu access
    typedef enum logic [3:0] {
        rom, ram, cpal, omem, vmem, vtimer,
        io_cab1, io_cab2, io_sys1, io_sys2,
        none
    } bus_region_e;

    typedef struct packed {
        logic [23:1] addr;      // word address
        logic        wr;
        logic [ 1:0] dsn;       // upper, lower byte strobe, active low
        logic [15:0] wdata;
    } bus_req_t;

    typedef struct packed {
        bus_region_e region;
        logic [21:1] ext_addr;  // rom/ram address after bank swap
        logic        ext;       // waits on rom_ok or ram_ok
    } bus_sel_t;

    typedef struct packed {
        logic [1:0] cpal_we;
        logic [1:0] omem_we;
        logic [1:0] vmem_we;
    } mem_we_t;

    typedef struct packed {
        logic       pri;
        logic       gvflip;
        logic       ghflip;
        logic       l_r;
        logic       l5mas;
        logic [3:0] psac_bank;
    } video_cfg_t;

    // memory map, upper byte address bits
    localparam logic [3:0] BOOT_HI   = 4'h0;        // $0x_xxxx
    localparam logic [3:0] XROM_HI_A = 4'h1;
    localparam logic [3:0] XROM_HI_B = 4'h2;
    localparam logic [4:0] RAM_HI    = 5'b0011_1;   // $38_xxxx
    localparam logic [4:0] CPAL_HI   = 5'b0011_0;   // $30_xxxx
    localparam logic [2:0] GFX_HI    = 3'b011;      // $6x and $7x
    localparam logic [2:0] MISC_HI   = 3'b010;      // $4x and $5x

    // 3-to-8 decoder codes on bits 20..18
    localparam logic [2:0] GFX_OMEM    = 3'd0;
    localparam logic [2:0] GFX_VMEM    = 3'd5;
    localparam logic [2:0] MISC_VTIMER = 3'd3;
    localparam logic [2:0] MISC_IO     = 3'd2;

    // io block split on bits 3..2
    localparam logic [1:0] IO_CAB1 = 2'd0;
    localparam logic [1:0] IO_CAB2 = 2'd1;
    localparam logic [1:0] IO_SYS1 = 2'd2;
    localparam logic [1:0] IO_SYS2 = 2'd3;

endpackage

`default_nettype wire
